/* src/panda_commit_pkg.sv */
`default_nettype none

package panda_commit_pkg;

	// error code carried by an instruction at commit
	typedef enum logic [2:0] {
		ERR_NONE         = 3'd0, // clean instruction
		ERR_ILLEGAL      = 3'd1, // illegal opcode
		ERR_PC_UNALIGNED = 3'd2, // fetch address misaligned
		ERR_IMEM_FAULT   = 3'd3, // fetch bus error
		ERR_LD_UNALIGNED = 3'd6, // load address misaligned
		ERR_ST_UNALIGNED = 3'd7  // store address misaligned
	} inst_err_e; // bit 0 or bit 1 set means sync fault

	typedef enum logic [7:0] {
		INST_MISALIGNED = 8'd0,
		INST_FAULT      = 8'd1,
		ILLEGAL         = 8'd2,
		LD_MISALIGNED   = 8'd4,
		LD_FAULT        = 8'd5,
		ST_MISALIGNED   = 8'd6,
		ST_FAULT        = 8'd7,
		ECALL_M         = 8'd11 // ecall from m-mode
	} expt_code_e;

	// interrupt codes reuse exception numbers, kept apart
	typedef enum logic [7:0] {
		M_SW  = 8'd3,
		M_TMR = 8'd7,
		M_EXT = 8'd11
	} intr_code_e;

	typedef enum logic {
		LSU_LD_FAULT = 1'b0, // load bus error
		LSU_ST_FAULT = 1'b1  // store bus error
	} lsu_err_e;

	typedef enum logic [1:0] {
		CSR_MSTATUS  = 2'd0, // mie bit 3, mpie bit 7
		CSR_MIE      = 2'd1, // msie 3, mtie 7, meie 11
		CSR_MTVEC    = 2'd2,
		CSR_MTIMECMP = 2'd3  // low word, zero-extended
	} csr_sel_e;

	typedef struct packed {
		logic [31:0] inst;       // fetched word
		inst_err_e   err;
		logic [31:0] pc;
		logic        is_b;       // conditional branch
		logic        is_ecall;
		logic        is_mret;
		logic [31:0] brc_pc_upd; // corrected pc on mispredict
		logic        prdt_jump;  // predicted taken
		logic        is_long;    // load/store or mul/div
		logic        cfr_jump;   // resolved taken
		logic [31:0] ls_addr;    // agu address, l/s only
	} commit_inst_t;

	typedef struct packed {
		logic [31:0] ls_addr; // faulting bus address
		lsu_err_e    err;
	} lsu_expt_t;

	typedef struct packed {
		logic mstatus_mie; // global enable
		logic msie;
		logic mtie;
		logic meie;
	} irq_en_t;

	typedef struct packed {
		logic        enter;    // pulse on transfer edge
		logic        is_intr;
		logic [7:0]  cause;
		logic [31:0] ret_addr; // goes to mepc
		logic [31:0] val;      // goes to mtval
	} trap_info_t;

	typedef struct packed {
		logic inst_cmt;      // 0 = cancelled
		logic need_imdt_wbk; // write rf now
	} cmt_result_t;

	typedef struct packed {
		logic        en; // one-cycle strobe
		csr_sel_e    sel;
		logic [31:0] data;
	} csr_wr_t;

endpackage

`default_nettype wire

/* src/commit_ctrl.sv */
`timescale 1ns/1ns
`default_nettype none

module commit_ctrl
(
	input wire clk,
	input wire resetn,

	input wire pst_valid,    // instruction waiting
	input wire res_ready,    // result sink ready
	input wire flush_req,    // from arbiter, transfer cycle only
	input wire flush_ack,
	input wire trap_enter,
	input wire itr_expt_ret, // mret retired

	output logic pst_ready,
	output logic res_valid,
	output logic cmt_fire,   // commit handshake done
	output logic trap_busy   // inside a trap handler
);

	typedef enum logic {
		CMT_RUN,        // accepting commits
		CMT_FLUSH_WAIT  // flush issued, no ack yet
	} cmt_state_e;

	cmt_state_e state;
	cmt_state_e state_nxt;
	logic stall;

	assign stall = (state == CMT_FLUSH_WAIT); // frontend still redirecting

	// one instruction in flight, ready only passes res_ready through when idle
	assign pst_ready = ~stall & res_ready;
	assign res_valid = pst_valid & pst_ready; // result only offered with a transfer
	assign cmt_fire  = pst_valid & pst_ready;

	always_comb
	begin
		state_nxt = state;
		case (state)
			CMT_RUN:
			begin
				if (flush_req & ~flush_ack) // ack same cycle means no stall
					state_nxt = CMT_FLUSH_WAIT;
			end
			CMT_FLUSH_WAIT:
			begin
				if (flush_ack)
					state_nxt = CMT_RUN;
			end
			default:
				state_nxt = CMT_RUN;
		endcase
	end

	always_ff @(posedge clk or negedge resetn)
	begin
		if (!resetn)
			state <= CMT_RUN;
		else
			state <= state_nxt;
	end

	// no nesting, set on entry and dropped on mret
	always_ff @(posedge clk or negedge resetn)
	begin
		if (!resetn)
			trap_busy <= 1'b0;
		else if (trap_enter)
			trap_busy <= 1'b1;
		else if (itr_expt_ret)
			trap_busy <= 1'b0;
	end

	// an unacked flush must block the next commit
	a_no_fire_in_wait: assert property (
		@(posedge clk) disable iff (!resetn)
		(flush_req && !flush_ack) |=> !cmt_fire
	) else $error("commit transfer while flush pending");

	// arbiter must never enter and leave a trap on one instruction
	a_enter_ret_excl: assert property (
		@(posedge clk) disable iff (!resetn)
		!(trap_enter && itr_expt_ret)
	) else $error("trap entry and mret in same cycle");

	// flush only ever raised alongside a handshake
	a_flush_on_fire: assert property (
		@(posedge clk) disable iff (!resetn)
		flush_req |-> cmt_fire
	) else $error("flush_req without commit transfer");

endmodule

`default_nettype wire

/* src/trap_arbiter.sv */
`timescale 1ns/1ns
`default_nettype none

module trap_arbiter
(
	input wire panda_commit_pkg::commit_inst_t pst,
	input wire pst_valid,
	input wire panda_commit_pkg::lsu_expt_t lsu,
	input wire lsu_valid,
	input wire cmt_fire,
	input wire trap_busy,
	input wire panda_commit_pkg::irq_en_t irq_en,
	input wire sw_itr_req,  // level
	input wire tmr_itr_req, // level from timer
	input wire ext_itr_req, // level
	input wire [31:0] mtvec,
	input wire [31:0] mepc,

	output panda_commit_pkg::trap_info_t trap,
	output logic itr_expt_ret,
	output logic lsu_ready,
	output panda_commit_pkg::cmt_result_t res,
	output logic flush_req,
	output logic [31:0] flush_addr
);

	logic has_fault;   // sync fault on this inst
	logic brc_mis;     // branch mispredicted
	logic ecall_inst;
	logic mret_inst;
	logic ext_vld, sw_vld, tmr_vld, lsu_vld, sync_vld;
	logic ext_gnt, sw_gnt, tmr_gnt, lsu_gnt, sync_gnt, ecall_gnt, mret_gnt;
	logic trap_gnt;    // any trap source granted
	logic [7:0] sync_cause;
	logic [31:0] sync_val;

	assign has_fault  = pst.err[0] | pst.err[1];
	assign brc_mis    = pst_valid & ~has_fault & pst.is_b & (pst.prdt_jump ^ pst.cfr_jump);
	assign ecall_inst = pst_valid & ~has_fault & pst.is_ecall;
	assign mret_inst  = pst_valid & ~has_fault & pst.is_mret;

	assign ext_vld  = irq_en.mstatus_mie & irq_en.meie & ext_itr_req;
	assign sw_vld   = irq_en.mstatus_mie & irq_en.msie & sw_itr_req;
	assign tmr_vld  = irq_en.mstatus_mie & irq_en.mtie & tmr_itr_req;
	assign lsu_vld  = ~trap_busy & lsu_valid; // dropped inside handler
	assign sync_vld = ~trap_busy & pst_valid & has_fault;

	// mispredict > ext > sw > tmr > lsu > sync/ecall, mret only if nothing else
	always_comb
	begin
		ext_gnt   = ~brc_mis & ext_vld;
		sw_gnt    = ~brc_mis & ~ext_vld & sw_vld;
		tmr_gnt   = ~brc_mis & ~ext_vld & ~sw_vld & tmr_vld;
		lsu_gnt   = ~brc_mis & ~ext_vld & ~sw_vld & ~tmr_vld & lsu_vld;
		sync_gnt  = ~brc_mis & ~ext_vld & ~sw_vld & ~tmr_vld & ~lsu_vld & sync_vld;
		ecall_gnt = ~brc_mis & ~ext_vld & ~sw_vld & ~tmr_vld & ~lsu_vld & ecall_inst;
		trap_gnt  = ext_gnt | sw_gnt | tmr_gnt | lsu_gnt | sync_gnt | ecall_gnt;
		mret_gnt  = ~brc_mis & ~trap_gnt & mret_inst;
		if (cmt_fire)
			a_one_grant: assert ($onehot0({brc_mis, ext_gnt, sw_gnt, tmr_gnt,
				lsu_gnt, sync_gnt, ecall_gnt, mret_gnt}))
				else $error("more than one commit grant");
	end

	// sync fault decode, cause and mtval together
	always_comb
	begin
		sync_cause = panda_commit_pkg::ILLEGAL;
		sync_val   = 32'd0;
		case (pst.err)
			panda_commit_pkg::ERR_ILLEGAL:
			begin
				sync_cause = panda_commit_pkg::ILLEGAL;
				sync_val   = pst.inst; // offending word
			end
			panda_commit_pkg::ERR_PC_UNALIGNED:
			begin
				sync_cause = panda_commit_pkg::INST_MISALIGNED;
				sync_val   = pst.pc;
			end
			panda_commit_pkg::ERR_IMEM_FAULT:
			begin
				sync_cause = panda_commit_pkg::INST_FAULT;
				sync_val   = pst.pc;
			end
			panda_commit_pkg::ERR_LD_UNALIGNED:
			begin
				sync_cause = panda_commit_pkg::LD_MISALIGNED;
				sync_val   = pst.ls_addr;
			end
			panda_commit_pkg::ERR_ST_UNALIGNED:
			begin
				sync_cause = panda_commit_pkg::ST_MISALIGNED;
				sync_val   = pst.ls_addr;
			end
			default:
			begin
				sync_cause = panda_commit_pkg::ILLEGAL; // not a fault, unused
				sync_val   = 32'd0;
			end
		endcase
	end

	always_comb
	begin
		trap.enter    = cmt_fire & trap_gnt;
		trap.is_intr  = ext_gnt | sw_gnt | tmr_gnt;
		trap.ret_addr = sync_gnt ? pst.pc : pst.pc + 32'd4; // sync faults re-execute
		trap.val      = 32'd0;
		if (ext_gnt)
			trap.cause = panda_commit_pkg::M_EXT;
		else if (sw_gnt)
			trap.cause = panda_commit_pkg::M_SW;
		else if (tmr_gnt)
			trap.cause = panda_commit_pkg::M_TMR;
		else if (lsu_gnt)
		begin
			trap.cause = (lsu.err == panda_commit_pkg::LSU_ST_FAULT) ?
				panda_commit_pkg::ST_FAULT : panda_commit_pkg::LD_FAULT;
			trap.val   = lsu.ls_addr; // bus address from lsu
		end
		else if (sync_gnt)
		begin
			trap.cause = sync_cause;
			trap.val   = sync_val;
		end
		else
			trap.cause = panda_commit_pkg::ECALL_M; // ecall or no trap
	end

	assign itr_expt_ret = cmt_fire & mret_gnt;
	assign lsu_ready    = cmt_fire & lsu_gnt; // lsu fault consumed with the commit

	assign flush_req  = cmt_fire & (brc_mis | trap_gnt | mret_gnt);
	assign flush_addr = brc_mis ? pst.brc_pc_upd :
		mret_gnt ? mepc : mtvec; // trap vector otherwise

	assign res.inst_cmt      = ~sync_gnt; // cancelled only by own fault
	assign res.need_imdt_wbk = ~sync_gnt & ~pst.is_long;

endmodule

`default_nettype wire

/* src/trap_csr.sv */
`timescale 1ns/1ns
`default_nettype none

module trap_csr #(
	parameter logic [31:0] MTVEC_RST = 32'h0000_0100 // trap vector after reset
)
(
	input wire clk,
	input wire resetn,

	input wire panda_commit_pkg::trap_info_t trap,
	input wire itr_expt_ret,         // mret retired
	input wire panda_commit_pkg::csr_wr_t csr_wr,

	output panda_commit_pkg::irq_en_t irq_en,
	output logic [31:0] mtvec,
	output logic [31:0] mepc
);

	logic mstatus_mie;  // global irq enable
	logic mstatus_mpie; // mie before trap
	logic mie_msie;
	logic mie_mtie;
	logic mie_meie;
	logic [31:0] mcause; // bit 31 = interrupt
	logic [31:0] mtval;
	logic wr_mstatus, wr_mie, wr_mtvec;

	assign wr_mstatus = csr_wr.en & (csr_wr.sel == panda_commit_pkg::CSR_MSTATUS);
	assign wr_mie     = csr_wr.en & (csr_wr.sel == panda_commit_pkg::CSR_MIE);
	assign wr_mtvec   = csr_wr.en & (csr_wr.sel == panda_commit_pkg::CSR_MTVEC);

	// entry beats mret beats software write
	always_ff @(posedge clk or negedge resetn)
	begin
		if (!resetn)
		begin
			mstatus_mie  <= 1'b0;
			mstatus_mpie <= 1'b0;
		end
		else if (trap.enter)
		begin
			mstatus_mie  <= 1'b0;          // no nesting
			mstatus_mpie <= mstatus_mie;
		end
		else if (itr_expt_ret)
		begin
			mstatus_mie  <= mstatus_mpie;
			mstatus_mpie <= 1'b1;
		end
		else if (wr_mstatus)
		begin
			mstatus_mie  <= csr_wr.data[3];
			mstatus_mpie <= csr_wr.data[7];
		end
	end

	always_ff @(posedge clk or negedge resetn)
	begin
		if (!resetn)
		begin
			mie_msie <= 1'b0;
			mie_mtie <= 1'b0;
			mie_meie <= 1'b0;
			mtvec    <= MTVEC_RST;
		end
		else
		begin
			if (wr_mie)
			begin
				mie_msie <= csr_wr.data[3];
				mie_mtie <= csr_wr.data[7];
				mie_meie <= csr_wr.data[11];
			end
			if (wr_mtvec)
				mtvec <= {csr_wr.data[31:2], 2'b00}; // direct mode only
		end
	end

	// trap record captured on the transfer edge
	always_ff @(posedge clk)
	begin
		if (trap.enter)
		begin
			mepc   <= trap.ret_addr;
			mcause <= {trap.is_intr, 23'd0, trap.cause};
			mtval  <= trap.val;
		end
	end

	assign irq_en = '{mstatus_mie: mstatus_mie, msie: mie_msie, mtie: mie_mtie, meie: mie_meie};

	// handler must start with interrupts masked even against a csr write
	a_mie_off_after_entry: assert property (
		@(posedge clk) disable iff (!resetn)
		trap.enter |=> !irq_en.mstatus_mie
	) else $error("mie still set after trap entry");

endmodule

`default_nettype wire

/* src/machine_timer.sv */
`timescale 1ns/1ns
`default_nettype none

module machine_timer #(
	parameter int MTIME_W = 64 // 32 or 64
)
(
	input wire clk,
	input wire resetn,

	input wire panda_commit_pkg::csr_wr_t csr_wr,

	output logic tmr_itr_req // level while mtime >= mtimecmp
);

	logic [MTIME_W-1:0] mtime;    // free-running
	logic [MTIME_W-1:0] mtimecmp;
	logic cmp_wr;                 // compare value load

	assign cmp_wr = csr_wr.en & (csr_wr.sel == panda_commit_pkg::CSR_MTIMECMP);

	always_ff @(posedge clk or negedge resetn)
	begin
		if (!resetn)
			mtime <= '0;
		else
			mtime <= mtime + 1'b1; // one tick per clk
	end

	// all ones keeps the timer quiet until software arms it
	always_ff @(posedge clk or negedge resetn)
	begin
		if (!resetn)
			mtimecmp <= '1;
		else if (cmp_wr)
			mtimecmp <= MTIME_W'(csr_wr.data); // zero-extended low word
	end

	assign tmr_itr_req = (mtime >= mtimecmp); // new cmp seen one cycle after strobe

endmodule

`default_nettype wire

/* src/commit_top.sv */
`timescale 1ns/1ns
`default_nettype none

module commit_top #(
	parameter int MTIME_W = 64,                       // mtime/mtimecmp width
	parameter logic [31:0] MTVEC_RST = 32'h0000_0100  // reset trap vector
)
(
	input wire clk,
	input wire resetn,

	input wire panda_commit_pkg::commit_inst_t pst,
	input wire pst_valid,
	output logic pst_ready,

	input wire panda_commit_pkg::lsu_expt_t lsu,
	input wire lsu_valid,
	output logic lsu_ready,

	output panda_commit_pkg::cmt_result_t res,
	output logic res_valid,
	input wire res_ready,

	input wire sw_itr_req,  // held until cleared
	input wire ext_itr_req, // held until cleared
	input wire panda_commit_pkg::csr_wr_t csr_wr,

	output panda_commit_pkg::trap_info_t trap,
	output logic itr_expt_ret,
	output logic flush_req,
	input wire flush_ack,
	output logic [31:0] flush_addr
);

	logic cmt_fire;                     // commit handshake
	logic trap_busy;                    // handler running
	panda_commit_pkg::irq_en_t irq_en;
	logic [31:0] mtvec;
	logic [31:0] mepc;
	logic tmr_itr_req;

	commit_ctrl commit_ctrl_inst (
		.clk(clk), .resetn(resetn),
		.pst_valid(pst_valid), .res_ready(res_ready),
		.flush_req(flush_req), .flush_ack(flush_ack),
		.trap_enter(trap.enter), .itr_expt_ret(itr_expt_ret),
		.pst_ready(pst_ready), .res_valid(res_valid),
		.cmt_fire(cmt_fire), .trap_busy(trap_busy)
	);

	trap_arbiter trap_arbiter_inst (
		.pst(pst), .pst_valid(pst_valid), .lsu(lsu), .lsu_valid(lsu_valid),
		.cmt_fire(cmt_fire), .trap_busy(trap_busy), .irq_en(irq_en),
		.sw_itr_req(sw_itr_req), .tmr_itr_req(tmr_itr_req), .ext_itr_req(ext_itr_req),
		.mtvec(mtvec), .mepc(mepc),
		.trap(trap), .itr_expt_ret(itr_expt_ret), .lsu_ready(lsu_ready), .res(res),
		.flush_req(flush_req), .flush_addr(flush_addr)
	);

	trap_csr #(.MTVEC_RST(MTVEC_RST)) trap_csr_inst (
		.clk(clk), .resetn(resetn),
		.trap(trap), .itr_expt_ret(itr_expt_ret), .csr_wr(csr_wr),
		.irq_en(irq_en), .mtvec(mtvec), .mepc(mepc)
	);

	machine_timer #(.MTIME_W(MTIME_W)) machine_timer_inst (
		.clk(clk), .resetn(resetn),
		.csr_wr(csr_wr),
		.tmr_itr_req(tmr_itr_req)
	);

endmodule

`default_nettype wire

/* sim/tb_commit.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_commit;

	localparam logic [31:0] MTVEC_RST = 32'h0000_0100;
	localparam panda_commit_pkg::csr_wr_t NO_WR = '0;

	typedef struct packed {
		panda_commit_pkg::commit_inst_t pi;
		logic                           lsu_v;
		panda_commit_pkg::lsu_expt_t    lsu;
		logic [1:0]                     irq;   // {ext, sw}
		panda_commit_pkg::csr_wr_t      wr;    // strobed one cycle before the commit
		logic [1:0]                     stall; // res_ready low cycles
		logic                           e_trap;
		logic                           e_intr;
		logic                           e_cmt;
		logic                           e_flush;
		logic                           e_ret;
		logic [7:0]                     cause;
	} row_t;

	logic clk;
	logic resetn;
	panda_commit_pkg::commit_inst_t pst;
	logic pst_valid, pst_ready;
	panda_commit_pkg::lsu_expt_t lsu;
	logic lsu_valid, lsu_ready;
	panda_commit_pkg::cmt_result_t res;
	logic res_valid, res_ready;
	logic sw_itr_req, ext_itr_req;
	panda_commit_pkg::csr_wr_t csr_wr;
	panda_commit_pkg::trap_info_t trap;
	logic itr_expt_ret, flush_req, flush_ack;
	logic [31:0] flush_addr;

	row_t tbl[$];
	logic table_built;
	logic [31:0] lfsr;
	int mism;          // wrong values
	int other;         // everything else
	int cur_row;
	logic m_mie;       // reference mstatus.MIE
	logic m_mpie;
	logic [31:0] m_mepc;

	commit_top #(.MTIME_W(64), .MTVEC_RST(MTVEC_RST)) commit_top_inst (
		.clk(clk), .resetn(resetn),
		.pst(pst), .pst_valid(pst_valid), .pst_ready(pst_ready),
		.lsu(lsu), .lsu_valid(lsu_valid), .lsu_ready(lsu_ready),
		.res(res), .res_valid(res_valid), .res_ready(res_ready),
		.sw_itr_req(sw_itr_req), .ext_itr_req(ext_itr_req), .csr_wr(csr_wr),
		.trap(trap), .itr_expt_ret(itr_expt_ret),
		.flush_req(flush_req), .flush_ack(flush_ack), .flush_addr(flush_addr)
	);

	initial
	begin
		clk = 1'b0;
		forever #10 clk = ~clk; // 20 ns period
	end

	// fibonacci taps 32 22 2 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic panda_commit_pkg::csr_wr_t csr_write(
		input panda_commit_pkg::csr_sel_e sel, input logic [31:0] data);
		panda_commit_pkg::csr_wr_t w;
		w.en   = 1'b1;
		w.sel  = sel;
		w.data = data;
		return w;
	endfunction

	// mtval rule per granted source
	function automatic logic [31:0] exp_val(input row_t r);
		if (!r.e_trap || r.e_intr)
			return 32'd0;
		case (r.cause)
			panda_commit_pkg::LD_FAULT, panda_commit_pkg::ST_FAULT: return r.lsu.ls_addr;
			panda_commit_pkg::LD_MISALIGNED, panda_commit_pkg::ST_MISALIGNED: return r.pi.ls_addr;
			panda_commit_pkg::INST_MISALIGNED, panda_commit_pkg::INST_FAULT: return r.pi.pc;
			panda_commit_pkg::ILLEGAL: return r.pi.inst;
			default: return 32'd0;
		endcase
	endfunction

	task automatic check_trap(input panda_commit_pkg::trap_info_t got,
		input panda_commit_pkg::trap_info_t exp);
		if (got.enter !== exp.enter || (exp.enter && got !== exp)) // fields only matter on entry
		begin
			mism++;
			$display("MISMATCH trap row %0d got %h exp %h", cur_row, got, exp);
		end
	endtask

	task automatic check_res(input panda_commit_pkg::cmt_result_t got,
		input panda_commit_pkg::cmt_result_t exp);
		if (got !== exp)
		begin
			mism++;
			$display("MISMATCH res row %0d got %h exp %h", cur_row, got, exp);
		end
	endtask

	task automatic check_addr(input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp)
		begin
			mism++;
			$display("MISMATCH flush_addr row %0d got %h exp %h", cur_row, got, exp);
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp)
		begin
			mism++;
			$display("MISMATCH %s row %0d got %h exp %h", name, cur_row, got, exp);
		end
	endtask

	// fl = {is_b, prdt, cfr, ecall, mret, long}, e = {trap, intr, cmt, flush, ret}
	task automatic add_row(input logic [2:0] err, input logic [5:0] fl, input logic [1:0] lsu_k,
		input logic [1:0] irq, input panda_commit_pkg::csr_wr_t wr, input logic [1:0] stall,
		input logic [4:0] e, input logic [7:0] cause);
		row_t r;
		logic [31:0] pc;
		pc = 32'h0000_1000 + 32'(tbl.size() * 16);
		r.pi.inst = {pc[19:0], 12'h013};
		r.pi.err  = panda_commit_pkg::inst_err_e'(err);
		r.pi.pc   = pc;
		{r.pi.is_b, r.pi.prdt_jump, r.pi.cfr_jump, r.pi.is_ecall, r.pi.is_mret, r.pi.is_long} = fl;
		r.pi.brc_pc_upd = pc + 32'h0000_0400;
		r.pi.ls_addr    = pc + 32'h0002_0001; // odd so misaligned
		r.lsu_v         = (lsu_k != 2'd0);
		r.lsu.ls_addr   = {16'h8000, pc[15:0]};
		r.lsu.err       = (lsu_k == 2'd2) ? panda_commit_pkg::LSU_ST_FAULT :
			panda_commit_pkg::LSU_LD_FAULT;
		r.irq   = irq;
		r.wr    = wr;
		r.stall = stall;
		{r.e_trap, r.e_intr, r.e_cmt, r.e_flush, r.e_ret} = e;
		r.cause = cause;
		tbl.push_back(r);
	endtask

	task automatic add_mret(input logic [1:0] stall);
		add_row(3'd0, 6'b000010, 2'd0, 2'b00, NO_WR, stall, 5'b00111, 8'd0);
	endtask

	task automatic build_table();
		add_row(3'd0, 6'b110000, 2'd0, 2'b00, NO_WR, 2'd2, 5'b00110, 8'd0);  // mispredict
		add_row(3'd0, 6'b111000, 2'd0, 2'b00, NO_WR, 2'd0, 5'b00100, 8'd0);  // prediction right
		add_row(3'd1, 6'b000000, 2'd0, 2'b00, NO_WR, 2'd1, 5'b10010, 8'd2);  // illegal
		add_mret(2'd0);
		add_row(3'd2, 6'b000000, 2'd0, 2'b00, NO_WR, 2'd0, 5'b10010, 8'd0);  // pc misaligned
		add_mret(2'd0);
		add_row(3'd3, 6'b000000, 2'd0, 2'b00, NO_WR, 2'd0, 5'b10010, 8'd1);  // fetch fault
		add_mret(2'd0);
		add_row(3'd6, 6'b000001, 2'd0, 2'b00, NO_WR, 2'd0, 5'b10010, 8'd4);  // load misaligned
		add_mret(2'd1);
		add_row(3'd7, 6'b000001, 2'd0, 2'b00, NO_WR, 2'd0, 5'b10010, 8'd6);  // store misaligned
		add_mret(2'd0);
		add_row(3'd0, 6'b000100, 2'd0, 2'b00, NO_WR, 2'd0, 5'b10110, 8'd11); // ecall
		add_row(3'd1, 6'b000000, 2'd0, 2'b00, NO_WR, 2'd0, 5'b00100, 8'd0);  // busy so no trap
		add_mret(2'd2);
		add_row(3'd0, 6'b000000, 2'd0, 2'b00, csr_write(panda_commit_pkg::CSR_MIE, 32'h888),
			2'd0, 5'b00100, 8'd0); // enables on but MIE still 0
		add_row(3'd1, 6'b000000, 2'd1, 2'b11, csr_write(panda_commit_pkg::CSR_MSTATUS, 32'h8),
			2'd0, 5'b11110, 8'd11); // ext beats all
		add_mret(2'd0);
		add_row(3'd0, 6'b000000, 2'd2, 2'b01, NO_WR, 2'd1, 5'b11110, 8'd3);  // sw over lsu
		add_mret(2'd0);
		add_row(3'd6, 6'b000001, 2'd1, 2'b00, csr_write(panda_commit_pkg::CSR_MTIMECMP, 32'h10),
			2'd0, 5'b11110, 8'd7); // timer over lsu
		add_row(3'd0, 6'b000010, 2'd0, 2'b00,
			csr_write(panda_commit_pkg::CSR_MTIMECMP, 32'hffff_ffff), 2'd0, 5'b00111, 8'd0);
		add_row(3'd0, 6'b000001, 2'd2, 2'b00, NO_WR, 2'd2, 5'b10110, 8'd7);  // store bus fault
		add_mret(2'd0);
		add_row(3'd1, 6'b000000, 2'd1, 2'b00, NO_WR, 2'd0, 5'b10110, 8'd5);  // lsu over illegal
		add_mret(2'd0);
		add_row(3'd0, 6'b000000, 2'd0, 2'b11, csr_write(panda_commit_pkg::CSR_MSTATUS, 32'h0),
			2'd0, 5'b00100, 8'd0); // masked
		add_row(3'd0, 6'b000100, 2'd0, 2'b10, NO_WR, 2'd1, 5'b10110, 8'd11); // ecall with ext masked
		add_mret(2'd0);
	endtask

	task automatic run_row(input row_t r);
		logic [1:0] dly;
		int d;
		int n;
		panda_commit_pkg::trap_info_t et;
		panda_commit_pkg::cmt_result_t er;
		logic e_lsu;
		lfsr = lfsr_next(lfsr);
		dly[1] = lfsr[0];
		lfsr = lfsr_next(lfsr);
		dly[0] = lfsr[0];
		d = int'(dly); // ack delay 0..3
		if (r.wr.en)
		begin
			@(negedge clk);
			csr_wr = r.wr;
			if (r.wr.sel == panda_commit_pkg::CSR_MSTATUS)
			begin
				m_mie  = r.wr.data[3];
				m_mpie = r.wr.data[7];
			end
		end
		@(negedge clk);
		csr_wr    = '0;
		pst       = r.pi;
		pst_valid = 1'b1;
		lsu       = r.lsu;
		lsu_valid = r.lsu_v;
		{ext_itr_req, sw_itr_req} = r.irq;
		for (n = 0; n < int'(r.stall); n++)
		begin
			res_ready = 1'b0;
			#5;
			check_flag("pst_ready", pst_ready, 1'b0); // sink holds the stage
			check_flag("res_valid", res_valid, 1'b0);
			@(negedge clk);
		end
		res_ready = 1'b1;
		flush_ack = r.e_flush && (d == 0); // same-cycle ack
		#5;
		if (!m_mie && trap.enter && trap.is_intr) // reference MIE is clear
		begin
			other++;
			$display("row %0d took an interrupt while MIE is clear", cur_row);
		end
		check_flag("pst_ready", pst_ready, 1'b1);
		check_flag("res_valid", res_valid, 1'b1);
		et.enter    = r.e_trap;
		et.is_intr  = r.e_intr;
		et.cause    = r.cause;
		et.ret_addr = r.e_cmt ? r.pi.pc + 32'd4 : r.pi.pc; // faulting inst re-executes
		et.val      = exp_val(r);
		check_trap(trap, et);
		er.inst_cmt      = r.e_cmt;
		er.need_imdt_wbk = r.e_cmt & ~r.pi.is_long;
		check_res(res, er);
		e_lsu = r.e_trap && !r.e_intr &&
			(r.cause == panda_commit_pkg::LD_FAULT || r.cause == panda_commit_pkg::ST_FAULT);
		check_flag("flush_req", flush_req, r.e_flush);
		check_flag("itr_expt_ret", itr_expt_ret, r.e_ret);
		check_flag("lsu_ready", lsu_ready, e_lsu);
		if (r.e_flush)
			check_addr(flush_addr, r.e_ret ? m_mepc : (r.e_trap ? MTVEC_RST : r.pi.brc_pc_upd));
		if (r.e_trap)
		begin
			m_mepc = et.ret_addr;
			m_mpie = m_mie;
			m_mie  = 1'b0;
		end
		else if (r.e_ret)
		begin
			m_mie  = m_mpie;
			m_mpie = 1'b1;
		end
		@(negedge clk);
		lsu_valid   = 1'b0;
		sw_itr_req  = 1'b0;
		ext_itr_req = 1'b0;
		flush_ack   = 1'b0;
		if (r.e_flush && d > 0)
		begin
			for (n = 1; n <= d; n++)  // pst stays offered and must not be taken
			begin
				flush_ack = (n == d);
				#5;
				check_flag("pst_ready", pst_ready, 1'b0);
				check_flag("res_valid", res_valid, 1'b0);
				@(negedge clk);
			end
			flush_ack = 1'b0;
		end
		pst_valid = 1'b0;
		#5;
		check_flag("pst_ready", pst_ready, 1'b1); // back to run
	endtask

	initial
	begin
		wait (table_built === 1'b1);
		repeat (16 + 40 * tbl.size()) @(posedge clk);
		$display("watchdog expired, the table did not finish in time (row %0d)", cur_row);
		$display("Simulation failed");
		$finish;
	end

	initial
	begin
		int i;
		resetn      = 1'b0;
		pst         = '0;
		pst_valid   = 1'b0;
		lsu         = '0;
		lsu_valid   = 1'b0;
		res_ready   = 1'b1;
		sw_itr_req  = 1'b0;
		ext_itr_req = 1'b0;
		csr_wr      = '0;
		flush_ack   = 1'b0;
		lfsr        = 32'h308a;
		mism        = 0;
		other       = 0;
		cur_row     = -1;
		m_mie       = 1'b0;
		m_mpie      = 1'b0;
		m_mepc      = 32'd0;
		table_built = 1'b0;
		build_table();
		table_built = 1'b1;
		repeat (16) @(negedge clk);
		resetn = 1'b1;
		#5;
		check_flag("pst_ready", pst_ready, 1'b1); // follows res_ready
		check_flag("res_valid", res_valid, 1'b0);
		check_flag("flush_req", flush_req, 1'b0);
		check_flag("trap.enter", trap.enter, 1'b0);
		check_flag("itr_expt_ret", itr_expt_ret, 1'b0);
		check_flag("lsu_ready", lsu_ready, 1'b0);
		for (i = 0; i < tbl.size(); i++)
		begin
			cur_row = i;
			run_row(tbl[i]);
		end
		@(negedge clk);
		$display("errors: %0d mismatches, %0d other failures", mism, other);
		if (mism == 0 && other == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire

/* panda_commit.f */
src/panda_commit_pkg.sv
src/commit_ctrl.sv
src/trap_arbiter.sv
src/trap_csr.sv
src/machine_timer.sv
src/commit_top.sv
sim/tb_commit.sv

/* Makefile */
# Verilator flow for the commit stage testbench

.PHONY: all lint clean

all:
	verilator --binary --timing --assert -Wno-fatal -f panda_commit.f \
		--top-module tb_commit -Mdir obj_dir -o tb_commit
	@out="$$(./obj_dir/tb_commit)"; echo "$$out"; \
		echo "$$out" | grep -qx "Simulation passed"

lint:
	verilator --lint-only --timing -f panda_commit.f --top-module tb_commit

clean:
	rm -rf obj_dir
